/* rtl/axi_pkg.sv */
// AXI write port widths, fixed size code
// burst type and response enums
package axi_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;
  localparam int id_w   = 2;
  localparam int len_w  = 8;

  localparam logic [2:0] size_word = 3'd2;  // 4-byte beats only

  typedef enum logic [1:0] {FIXED = 2'b00, INCR = 2'b01, WRAP = 2'b10} axi_burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

endpackage

/* rtl/bridge_pkg.sv */
// requestor count, split limits, burst descriptor
// and the issue FSM states
package bridge_pkg;

  import axi_pkg::*;

  localparam int n_req           = 3;
  localparam int req_w           = 2;
  localparam int bcnt_w          = 13;  // 4096 still fits
  localparam int page_bytes      = 4096;
  localparam int max_beats       = 16;
  localparam int max_burst_bytes = max_beats * strb_w;
  localparam int fifo_depth      = 4;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [len_w-1:0]  len;   // beats minus one
    logic [req_w-1:0]  req;
    logic              last;  // final burst of the request
  } burst_desc_t;

  typedef enum logic [1:0] {IDLE, ADDR, DATA, RESP} wr_state_e;

endpackage

/* rtl/burst_if.sv */
// valid/ready channel for burst descriptors
`timescale 1ns/100ps

interface burst_if import bridge_pkg::*; ();

  logic        valid;
  logic        ready;
  burst_desc_t desc;   // held with valid until taken

  modport src (output valid, output desc, input ready);

  modport dst (input valid, input desc, output ready);

endinterface

/* rtl/wr_arbiter.sv */
// round-robin write arbiter, grant held until the transfer is done
`timescale 1ns/100ps

module wr_arbiter
  import bridge_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic [n_req-1:0] req_start,
  input  logic             xfer_done,
  output logic [n_req-1:0] grant,
  output logic             start,
  output logic [req_w-1:0] grant_idx
);

  logic [n_req-1:0] pending;   // starts seen while busy
  logic [n_req-1:0] req_any;
  logic [n_req-1:0] pick_mask;
  logic [req_w-1:0] last_idx;
  logic [req_w-1:0] pick_idx;
  logic             pick_ok;
  logic             busy;

  assign req_any   = pending | req_start;
  assign pick_mask = n_req'(1) << pick_idx;

  // first requestor after the one served last
  always_comb begin
    int cand;
    pick_ok  = 1'b0;
    pick_idx = last_idx;
    for (int i = 1; i <= n_req; i++) begin
      cand = int'(last_idx) + i;
      if (cand >= n_req) begin
        cand = cand - n_req;
      end
      if (!pick_ok && req_any[cand]) begin
        pick_ok  = 1'b1;
        pick_idx = req_w'(cand);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending   <= '0;
      busy      <= 1'b0;
      grant     <= '0;
      start     <= 1'b0;
      grant_idx <= '0;
      last_idx  <= req_w'(n_req - 1);  // requestor 0 goes first
    end else begin
      start <= 1'b0;
      if (!busy && pick_ok) begin
        busy      <= 1'b1;
        start     <= 1'b1;
        grant     <= pick_mask;
        grant_idx <= pick_idx;
        last_idx  <= pick_idx;
        pending   <= req_any & ~pick_mask;
      end else begin
        pending <= req_any;
      end
      if (busy && xfer_done) begin
        busy  <= 1'b0;   // grant drops the cycle after done
        grant <= '0;
      end
    end
  end

endmodule

/* rtl/boundary_splitter.sv */
// splits a granted request into INCR bursts that stay inside
// a 4 KB page and carry at most 16 beats
`timescale 1ns/100ps

module boundary_splitter
  import axi_pkg::*;
  import bridge_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  logic [req_w-1:0]  req_idx,
  input  logic [addr_w-1:0] addr,
  input  logic [bcnt_w-1:0] bytes,
  burst_if.src              bursts
);

  logic              active;
  logic [addr_w-1:0] cur_addr;
  logic [bcnt_w-1:0] left;      // bytes still to be cut
  logic [req_w-1:0]  cur_req;
  logic [bcnt_w-1:0] to_page;
  logic [bcnt_w-1:0] chunk;
  logic              last_one;
  logic              take;

  assign to_page = bcnt_w'(page_bytes - (cur_addr % page_bytes));

  // smallest of bytes left, room in the page and the burst cap
  always_comb begin
    chunk = left;
    if (to_page < chunk) begin
      chunk = to_page;
    end
    if (bcnt_w'(max_burst_bytes) < chunk) begin
      chunk = bcnt_w'(max_burst_bytes);
    end
  end

  assign last_one     = (chunk == left);
  assign take         = active && bursts.ready;
  assign bursts.valid = active;
  assign bursts.desc  = '{addr: cur_addr,
                          len:  len_w'(chunk / strb_w - 1),
                          req:  cur_req,
                          last: last_one};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active <= 1'b0;
    end else if (start) begin
      active <= 1'b1;
    end else if (take && last_one) begin
      active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      cur_addr <= addr;
      left     <= bytes;
      cur_req  <= req_idx;
    end else if (take) begin
      cur_addr <= cur_addr + addr_w'(chunk);  // step to next burst
      left     <= left - chunk;
    end
  end

endmodule

/* rtl/burst_fifo.sv */
// four-entry circular queue of burst descriptors
`timescale 1ns/100ps

module burst_fifo
  import bridge_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  burst_if.dst wr_side,
  burst_if.src rd_side
);

  burst_desc_t                   mem [fifo_depth];
  logic [$clog2(fifo_depth)-1:0] wr_ptr;
  logic [$clog2(fifo_depth)-1:0] rd_ptr;
  logic [$clog2(fifo_depth):0]   count;
  logic                          do_wr;
  logic                          do_rd;

  assign wr_side.ready = (count != fifo_depth);  // low when full
  assign rd_side.valid = (count != 0);
  assign rd_side.desc  = mem[rd_ptr];
  assign do_wr         = wr_side.valid && wr_side.ready;
  assign do_rd         = rd_side.valid && rd_side.ready;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_side.desc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* rtl/beat_counter.sv */
// down-counter of remaining W beats, flags the last one
`timescale 1ns/100ps

module beat_counter
  import axi_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             load,
  input  logic [len_w-1:0] beats,
  input  logic             beat,
  output logic             last_beat
);

  logic [len_w-1:0] remaining;  // beats after the current one

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      remaining <= '0;
    end else if (load) begin
      remaining <= beats;  // awlen, so zero means one beat
    end else if (beat && remaining != '0) begin
      remaining <= remaining - 1'b1;
    end
  end

  assign last_beat = (remaining == '0);

endmodule

/* rtl/wr_burst_fsm.sv */
// issues one burst at a time on AW, W and B
// and reports done and error per request
`timescale 1ns/100ps

module wr_burst_fsm
  import axi_pkg::*;
  import bridge_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  burst_if.dst              bursts,
  output logic [id_w-1:0]   awid,
  output logic [addr_w-1:0] awaddr,
  output logic [len_w-1:0]  awlen,
  output logic [2:0]        awsize,
  output logic [1:0]        awburst,
  output logic              awvalid,
  input  logic              awready,
  output logic [data_w-1:0] wdata,
  output logic [strb_w-1:0] wstrb,
  output logic              wlast,
  output logic              wvalid,
  input  logic              wready,
  input  logic [id_w-1:0]   bid,
  input  logic [1:0]        bresp,
  input  logic              bvalid,
  output logic              bready,
  input  logic [data_w-1:0] rd_data,
  output logic              data_pop,
  output logic              xfer_done,
  output logic              xfer_err
);

  wr_state_e   state;
  burst_desc_t cur;
  logic        err_acc;    // sticky over bursts of one request
  logic        last_beat;
  logic        bad_resp;
  logic        take;

  assign bursts.ready = (state == IDLE);
  assign take         = bursts.valid && bursts.ready;

  assign awid    = id_w'(cur.req);  // ID is the requestor index
  assign awaddr  = cur.addr;
  assign awlen   = cur.len;
  assign awsize  = size_word;
  assign awburst = INCR;
  assign awvalid = (state == ADDR);

  assign wdata    = rd_data;  // head of show-ahead FIFO
  assign wstrb    = '1;
  assign wvalid   = (state == DATA);
  assign wlast    = wvalid && last_beat;
  assign data_pop = wvalid && wready;

  assign bready   = (state == RESP);
  assign bad_resp = (bresp != OKAY) || (bid != id_w'(cur.req));

  beat_counter u_beat_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (take),
    .beats     (bursts.desc.len),
    .beat      (data_pop),
    .last_beat (last_beat)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (take) state <= ADDR;
        ADDR:    if (awready) state <= DATA;
        DATA:    if (wready && last_beat) state <= RESP;
        RESP:    if (bvalid) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      cur <= bursts.desc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      xfer_done <= 1'b0;
      xfer_err  <= 1'b0;
      err_acc   <= 1'b0;
    end else begin
      xfer_done <= 1'b0;
      xfer_err  <= 1'b0;
      if (bready && bvalid) begin
        if (cur.last) begin
          xfer_done <= 1'b1;  // one-cycle pulse with err
          xfer_err  <= err_acc || bad_resp;
          err_acc   <= 1'b0;
        end else begin
          err_acc <= err_acc || bad_resp;
        end
      end
    end
  end

endmodule

/* rtl/axi_wr_bridge.sv */
// write-only AXI bridge top: arbiter, splitter, descriptor FIFO, burst FSM
// plus request mux and per-requestor steering
`timescale 1ns/100ps

module axi_wr_bridge
  import axi_pkg::*;
  import bridge_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  // requestors
  input  logic [n_req-1:0]  req_start,
  output logic [n_req-1:0]  req_grant,
  output logic [n_req-1:0]  req_done,
  output logic [n_req-1:0]  req_err,
  output logic [n_req-1:0]  req_rd,
  input  logic [addr_w-1:0] req_addr  [n_req],
  input  logic [data_w-1:0] req_data  [n_req],
  input  logic [bcnt_w-1:0] req_bytes [n_req],
  // AW channel
  output logic [id_w-1:0]   awid,
  output logic [addr_w-1:0] awaddr,
  output logic [len_w-1:0]  awlen,
  output logic [2:0]        awsize,
  output logic [1:0]        awburst,
  output logic              awvalid,
  input  logic              awready,
  // W channel
  output logic [data_w-1:0] wdata,
  output logic [strb_w-1:0] wstrb,
  output logic              wlast,
  output logic              wvalid,
  input  logic              wready,
  // B channel
  input  logic [id_w-1:0]   bid,
  input  logic [1:0]        bresp,
  input  logic              bvalid,
  output logic              bready
);

  logic [n_req-1:0]  grant;
  logic [req_w-1:0]  grant_idx;
  logic              start;
  logic              xfer_done;
  logic              xfer_err;
  logic              data_pop;
  logic [data_w-1:0] rd_data;

  burst_if u_split_if ();  // splitter to queue
  burst_if u_issue_if ();  // queue to FSM

  assign rd_data   = req_data[grant_idx];
  assign req_grant = grant;
  assign req_rd    = grant & {n_req{data_pop}};   // pop only the granted FIFO
  assign req_done  = grant & {n_req{xfer_done}};
  assign req_err   = grant & {n_req{xfer_err}};

  wr_arbiter u_wr_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_start (req_start),
    .xfer_done (xfer_done),
    .grant     (grant),
    .start     (start),
    .grant_idx (grant_idx)
  );

  boundary_splitter u_boundary_splitter (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .req_idx (grant_idx),
    .addr    (req_addr[grant_idx]),
    .bytes   (req_bytes[grant_idx]),
    .bursts  (u_split_if.src)
  );

  burst_fifo u_burst_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_side (u_split_if.dst),
    .rd_side (u_issue_if.src)
  );

  wr_burst_fsm u_wr_burst_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .bursts    (u_issue_if.dst),
    .awid      (awid),
    .awaddr    (awaddr),
    .awlen     (awlen),
    .awsize    (awsize),
    .awburst   (awburst),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wlast     (wlast),
    .wvalid    (wvalid),
    .wready    (wready),
    .bid       (bid),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .rd_data   (rd_data),
    .data_pop  (data_pop),
    .xfer_done (xfer_done),
    .xfer_err  (xfer_err)
  );

endmodule

/* tests/axi_wr_bridge_props.sv */
// handshake stability and grant properties for the write bridge
`timescale 1ns/100ps

module axi_wr_bridge_props
  import axi_pkg::*;
  import bridge_pkg::*;
(
  input logic              clk,
  input logic              rst_n,
  input logic              awvalid,
  input logic              awready,
  input logic [addr_w-1:0] awaddr,
  input logic [len_w-1:0]  awlen,
  input logic [id_w-1:0]   awid,
  input logic              wvalid,
  input logic              wready,
  input logic [data_w-1:0] wdata,
  input logic              wlast,
  input logic [n_req-1:0]  req_grant,
  input logic [n_req-1:0]  req_done
);

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen) && $stable(awid))
    else $error("AW valid or payload changed before awready");

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
    else $error("W valid or payload changed before wready");

  grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(req_grant))
    else $error("more than one grant high");

  // grant may only move after the done pulse
  grant_held: assert property (@(posedge clk) disable iff (!rst_n)
    (req_grant != '0) && (req_done == '0) |=> $stable(req_grant))
    else $error("grant changed before its transfer was done");

endmodule

/* tests/wr_checker.sv */
// predicts bursts, data and done/err from the stimulus table
// and compares them with the DUT traffic
`timescale 1ns/100ps

module wr_checker
  import axi_pkg::*;
  import bridge_pkg::*;
#(
  parameter int n_ent = 8
)(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              table_ready,
  input  logic [req_w-1:0]  t_req   [n_ent],
  input  logic [addr_w-1:0] t_addr  [n_ent],
  input  logic [bcnt_w-1:0] t_bytes [n_ent],
  input  logic              t_err   [n_ent],
  input  logic              awvalid,
  input  logic              awready,
  input  logic [addr_w-1:0] awaddr,
  input  logic [len_w-1:0]  awlen,
  input  logic [2:0]        awsize,
  input  logic [1:0]        awburst,
  input  logic [id_w-1:0]   awid,
  input  logic              wvalid,
  input  logic              wready,
  input  logic [data_w-1:0] wdata,
  input  logic [strb_w-1:0] wstrb,
  input  logic              wlast,
  input  logic [n_req-1:0]  req_done,
  input  logic [n_req-1:0]  req_err,
  output int                errors,
  output int                tests_done
);

  logic [addr_w-1:0] exp_addr [$];
  logic [len_w-1:0]  exp_len  [$];
  logic [id_w-1:0]   exp_id   [$];
  logic [len_w-1:0]  w_len    [$];   // bursts whose data is still due
  logic [id_w-1:0]   w_id     [$];
  int                done_ent [$];   // table order is done order
  int                seq      [n_req];
  int                beat_idx;
  int                errs_before;

  task automatic report_err(input string name, input logic [31:0] exp, input logic [31:0] got);
    errors++;
    $display("ERR %s exp %h got %h", name, exp, got);
  endtask

  // split each request by the page and burst-size rule
  initial begin
    int a;
    int left;
    int room;
    int n;
    errors      = 0;
    tests_done  = 0;
    beat_idx    = 0;
    errs_before = 0;
    for (int r = 0; r < n_req; r++) begin
      seq[r] = 0;
    end
    wait (table_ready);
    for (int e = 0; e < n_ent; e++) begin
      a    = int'(t_addr[e]);
      left = int'(t_bytes[e]);
      while (left > 0) begin
        room = page_bytes - (a % page_bytes);
        n    = left;
        if (room < n) begin
          n = room;
        end
        if (max_burst_bytes < n) begin
          n = max_burst_bytes;
        end
        exp_addr.push_back(addr_w'(a));
        exp_len.push_back(len_w'(n / 4 - 1));
        exp_id.push_back(id_w'(t_req[e]));
        a    = a + n;
        left = left - n;
      end
      done_ent.push_back(e);
    end
  end

  task automatic check_aw();
    if (exp_addr.size() == 0) begin
      errors++;
      $display("unexpected AW burst at address %h", awaddr);
    end else begin
      if (awaddr !== exp_addr[0]) report_err("awaddr", exp_addr[0], awaddr);
      if (awlen !== exp_len[0]) report_err("awlen", exp_len[0], awlen);
      if (awid !== exp_id[0]) report_err("awid", exp_id[0], awid);
      if (awsize !== 3'd2) report_err("awsize", 3'd2, awsize);       // 4-byte beats
      if (awburst !== 2'b01) report_err("awburst", 2'b01, awburst);  // incr
      w_len.push_back(exp_len.pop_front());
      w_id.push_back(exp_id.pop_front());
      void'(exp_addr.pop_front());
    end
  endtask

  task automatic check_w();
    logic [data_w-1:0] exp_data;
    logic              exp_last;
    if (w_len.size() == 0) begin
      errors++;
      $display("W beat arrived with no burst open");
    end else begin
      exp_data = {8'(w_id[0]), 24'(seq[w_id[0]])};  // index, then running count
      exp_last = (beat_idx == int'(w_len[0]));
      if (wdata !== exp_data) report_err("wdata", exp_data, wdata);
      if (wlast !== exp_last) report_err("wlast", exp_last, wlast);
      if (wstrb !== 4'hf) report_err("wstrb", 4'hf, wstrb);  // full words only
      seq[w_id[0]]++;
      if (exp_last) begin
        beat_idx = 0;
        void'(w_len.pop_front());
        void'(w_id.pop_front());
      end else begin
        beat_idx++;
      end
    end
  endtask

  task automatic check_done();
    int               e;
    int               terrs;
    logic [n_req-1:0] exp_mask;
    if (done_ent.size() == 0) begin
      errors++;
      $display("req_done pulsed with no request open");
    end else begin
      e        = done_ent.pop_front();
      exp_mask = n_req'(1) << t_req[e];
      if (req_done !== exp_mask) report_err("req_done", exp_mask, req_done);
      if (req_err !== (t_err[e] ? exp_mask : '0)) begin
        report_err("req_err", t_err[e] ? exp_mask : '0, req_err);
      end
      tests_done++;
      terrs       = errors - errs_before;
      errs_before = errors;
      if (terrs == 0) begin
        $display("test %0d: req %0d, %0d bytes at %h ok", e, t_req[e], t_bytes[e], t_addr[e]);
      end else begin
        $display("test %0d: req %0d, %0d bytes at %h, %0d errors", e, t_req[e], t_bytes[e],
                 t_addr[e], terrs);
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      if (awvalid && awready) check_aw();
      if (wvalid && wready) check_w();
      if (req_done != '0 || req_err != '0) check_done();
    end
  end

endmodule

/* tests/tb_axi_wr_bridge.sv */
// testbench for the write bridge: clock, reset, stimulus table,
// requestor FIFO models, random-stall AXI slave and watchdog
`timescale 1ns/100ps

module tb_axi_wr_bridge
  import axi_pkg::*;
  import bridge_pkg::*;
();

  localparam int n_ent = 8;

  logic              clk = 1'b0;
  logic              rst_n;
  logic [n_req-1:0]  req_start;
  logic [n_req-1:0]  req_grant;
  logic [n_req-1:0]  req_done;
  logic [n_req-1:0]  req_err;
  logic [n_req-1:0]  req_rd;
  logic [addr_w-1:0] req_addr  [n_req];
  logic [data_w-1:0] req_data  [n_req] = '{default: '0};
  logic [bcnt_w-1:0] req_bytes [n_req];
  logic [id_w-1:0]   awid;
  logic [addr_w-1:0] awaddr;
  logic [len_w-1:0]  awlen;
  logic [2:0]        awsize;
  logic [1:0]        awburst;
  logic              awvalid;
  logic              awready = 1'b0;
  logic [data_w-1:0] wdata;
  logic [strb_w-1:0] wstrb;
  logic              wlast;
  logic              wvalid;
  logic              wready = 1'b0;
  logic [id_w-1:0]   bid = '0;
  logic [1:0]        bresp = 2'b00;
  logic              bvalid = 1'b0;
  logic              bready;

  // stimulus table, one row per request
  logic [req_w-1:0]  t_req   [n_ent];
  logic [addr_w-1:0] t_addr  [n_ent];
  logic [bcnt_w-1:0] t_bytes [n_ent];
  axi_resp_e         t_resp  [n_ent];
  int                t_bad   [n_ent];   // burst that gets t_resp, -1 for none
  logic              t_err   [n_ent];   // expected req_err
  logic              t_with_next [n_ent];
  logic              table_ready = 1'b0;

  int               errors;
  int               tests_done;
  int               active_entry [n_req] = '{default: 0};
  int               burst_no [n_req] = '{default: 0};
  int               seq_cnt [n_req] = '{default: 0};
  int               ent;
  logic [n_req-1:0] pop_q = '0;
  logic [id_w-1:0]  aw_id_q = '0;
  logic             wl_hs = 1'b0;
  logic             b_hs = 1'b0;
  logic             resp_pend = 1'b0;
  logic [31:0]      rnd = 32'h3a53;

  always #50 clk = ~clk;

  axi_wr_bridge u_axi_wr_bridge (.*);

  wr_checker #(.n_ent(n_ent)) u_wr_checker (.*);

  bind axi_wr_bridge axi_wr_bridge_props u_axi_wr_bridge_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .awlen     (awlen),
    .awid      (awid),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .wlast     (wlast),
    .req_grant (req_grant),
    .req_done  (req_done)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic set_entry(input int idx, input int req, input logic [31:0] addr,
                           input int bytes, input axi_resp_e resp, input int bad,
                           input logic err, input logic with_next);
    t_req[idx]       = req_w'(req);
    t_addr[idx]      = addr;
    t_bytes[idx]     = bcnt_w'(bytes);
    t_resp[idx]      = resp;
    t_bad[idx]       = bad;
    t_err[idx]       = err;
    t_with_next[idx] = with_next;
  endtask

  // show-ahead requestor FIFOs, next word visible after the pop
  always @(posedge clk) pop_q <= req_rd;

  always @(negedge clk) begin
    for (int r = 0; r < n_req; r++) begin
      if (!rst_n) begin
        seq_cnt[r] = 0;
      end else if (pop_q[r]) begin
        seq_cnt[r] = seq_cnt[r] + 1;
      end
      req_data[r] = {8'(r), 24'(seq_cnt[r])};
    end
  end

  // slave side bookkeeping at the clock edge
  always @(posedge clk) begin
    wl_hs <= wvalid && wready && wlast;
    b_hs  <= bvalid && bready;
    if (awvalid && awready) begin
      aw_id_q <= awid;
    end
    for (int r = 0; r < n_req; r++) begin
      if (!rst_n || req_done[r]) begin
        burst_no[r] <= 0;
      end else if (bvalid && bready && bid == id_w'(r)) begin
        burst_no[r] <= burst_no[r] + 1;
      end
    end
  end

  always @(negedge clk) begin
    if (!rst_n) begin
      awready   = 1'b0;
      wready    = 1'b0;
      bvalid    = 1'b0;
      resp_pend = 1'b0;
    end else begin
      rnd     = lcg_next(rnd);
      awready = (rnd[31:30] != 2'b00);   // ready about 3 cycles in 4
      rnd     = lcg_next(rnd);
      wready  = (rnd[31:30] != 2'b00);
      if (b_hs) begin
        bvalid = 1'b0;
      end
      if (wl_hs) begin
        resp_pend = 1'b1;
      end
      rnd = lcg_next(rnd);
      if (resp_pend && !bvalid && rnd[31]) begin
        ent       = active_entry[aw_id_q];
        bid       = aw_id_q;
        bresp     = (burst_no[aw_id_q] == t_bad[ent]) ? t_resp[ent] : OKAY;
        bvalid    = 1'b1;
        resp_pend = 1'b0;
      end
    end
  end

  initial begin
    int total_beats;
    total_beats = 0;
    wait (table_ready);
    for (int e = 0; e < n_ent; e++) begin
      total_beats += int'(t_bytes[e]) / 4;
    end
    repeat (total_beats * 40) @(posedge clk);
    $display("timeout after %0d cycles, not every request completed", total_beats * 40);
    $display("tests failed");
    $finish;
  end

  initial begin
    int i;
    int j;
    int r;
    rst_n     = 1'b0;
    req_start = '0;
    for (int k = 0; k < n_req; k++) begin
      req_addr[k]  = '0;
      req_bytes[k] = '0;
    end
    set_entry(0, 0, 32'h0000_1000, 4, OKAY, -1, 1'b0, 1'b0);     // single beat
    set_entry(1, 1, 32'h0000_2fa0, 256, OKAY, -1, 1'b0, 1'b0);   // crosses a page
    set_entry(2, 2, 32'h0000_4000, 128, SLVERR, 1, 1'b1, 1'b0);
    set_entry(3, 2, 32'h0000_5000, 64, OKAY, -1, 1'b0, 1'b0);    // err clears
    set_entry(4, 0, 32'h0000_a000, 12, OKAY, -1, 1'b0, 1'b0);    // req 0 served last
    set_entry(5, 1, 32'h0000_7f00, 512, DECERR, 5, 1'b1, 1'b1);  // all three at once
    set_entry(6, 2, 32'h0000_8ff8, 16, OKAY, -1, 1'b0, 1'b1);
    set_entry(7, 0, 32'h0000_6010, 40, OKAY, -1, 1'b0, 1'b0);
    table_ready = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    i = 0;
    while (i < n_ent) begin
      j = i;
      while (t_with_next[j] && j < n_ent - 1) begin
        j++;
      end
      @(negedge clk);
      for (int k = i; k <= j; k++) begin
        r               = int'(t_req[k]);
        req_addr[r]     = t_addr[k];
        req_bytes[r]    = t_bytes[k];
        active_entry[r] = k;
        req_start[r]    = 1'b1;
      end
      @(negedge clk);
      req_start = '0;
      wait (tests_done == j + 1);
      i = j + 1;
    end
    repeat (10) @(posedge clk);   // let stray traffic show up
    $display("%0d of %0d tests run, %0d errors", tests_done, n_ent, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* axi_wr_bridge.f */
rtl/axi_pkg.sv
rtl/bridge_pkg.sv
rtl/burst_if.sv
rtl/wr_arbiter.sv
rtl/boundary_splitter.sv
rtl/burst_fifo.sv
rtl/beat_counter.sv
rtl/wr_burst_fsm.sv
rtl/axi_wr_bridge.sv
tests/axi_wr_bridge_props.sv
tests/wr_checker.sv
tests/tb_axi_wr_bridge.sv

/* Bender.yml */
package:
  name: axi_wr_bridge

sources:
  - rtl/axi_pkg.sv
  - rtl/bridge_pkg.sv
  - rtl/burst_if.sv
  - rtl/wr_arbiter.sv
  - rtl/boundary_splitter.sv
  - rtl/burst_fifo.sv
  - rtl/beat_counter.sv
  - rtl/wr_burst_fsm.sv
  - rtl/axi_wr_bridge.sv
  - target: test
    files:
      - tests/axi_wr_bridge_props.sv
      - tests/wr_checker.sv
      - tests/tb_axi_wr_bridge.sv
